/* addrDecode.f */
opbPkg.sv
opbAddrDecoder.sv
opbReadReturn.sv
addrDecode.sv
opbClockGen.sv
addrDecodeChecker.sv
addrDecode_assertions.sv
addrDecodeTb.sv

/* addrDecode.sv */
`timescale 1ns/1ps

// OPB address decoder top level
// Per-peripheral read and write strobes in the access cycle, read data
// returned on decDo one cycle later

module addrDecode #(
    parameter int DataWidth = opbPkg::OpbDataWidth,
    parameter int AddrWidth = opbPkg::OpbAddrWidth
) (
    input  logic                  OPB_CLK,
    input  logic                  OPB_RST,

    // Bus side
    input  logic                  decRe,
    input  logic                  decWe,
    input  logic [AddrWidth-1:0]  decAddr,
    output logic [DataWidth-1:0]  decDo,

    // Peripheral read words
    input  logic [DataWidth-1:0]  counterData,
    input  logic [DataWidth-1:0]  scratchData,
    input  logic [DataWidth-1:0]  clockGenData,
    input  logic [DataWidth-1:0]  adcData,
    input  logic [DataWidth-1:0]  gantryMotorData,
    input  logic [DataWidth-1:0]  liftMotorData,
    input  logic [DataWidth-1:0]  eepromData,
    input  logic [DataWidth-1:0]  gpioData,

    // Peripheral strobes
    output opbPkg::periphStrobe_t readStrobe,
    output opbPkg::periphStrobe_t writeStrobe
);

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    opbAddrDecoder #(
        .AddrWidth (AddrWidth)
    ) decoder (
        .decRe       (decRe),
        .decWe       (decWe),
        .decAddr     (decAddr),
        .readStrobe  (readStrobe),
        .writeStrobe (writeStrobe)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////////////////////

    opbReadReturn #(
        .DataWidth (DataWidth)
    ) readReturn (
        .OPB_CLK         (OPB_CLK),
        .OPB_RST         (OPB_RST),
        .readStrobe      (readStrobe),
        .counterData     (counterData),
        .scratchData     (scratchData),
        .clockGenData    (clockGenData),
        .adcData         (adcData),
        .gantryMotorData (gantryMotorData),
        .liftMotorData   (liftMotorData),
        .eepromData      (eepromData),
        .gpioData        (gpioData),
        .decDo           (decDo)
    );

endmodule

/* addrDecodeChecker.sv */
`timescale 1ns/1ps

// Checker for the OPB address decoder
// Predicts strobes and read-return data from the address map and
// compares them with the DUT outputs in the middle of each cycle

module addrDecodeChecker #(
    parameter int DataWidth = opbPkg::OpbDataWidth,
    parameter int AddrWidth = opbPkg::OpbAddrWidth
) (
    input  logic                  OPB_CLK,
    input  logic                  OPB_RST,
    input  logic                  decRe,
    input  logic                  decWe,
    input  logic [AddrWidth-1:0]  decAddr,
    input  logic [DataWidth-1:0]  counterData,
    input  logic [DataWidth-1:0]  scratchData,
    input  logic [DataWidth-1:0]  clockGenData,
    input  logic [DataWidth-1:0]  adcData,
    input  logic [DataWidth-1:0]  gantryMotorData,
    input  logic [DataWidth-1:0]  liftMotorData,
    input  logic [DataWidth-1:0]  eepromData,
    input  logic [DataWidth-1:0]  gpioData,
    input  opbPkg::periphStrobe_t readStrobe,
    input  opbPkg::periphStrobe_t writeStrobe,
    input  logic [DataWidth-1:0]  decDo,
    output int                    errorCount,
    output int                    checkCount
);

    import opbPkg::*;

    int errors = 0;
    int checks = 0;

    // Read target of the previous cycle, -1 for none
    int prevTarget = -1;

    assign errorCount = errors;
    assign checkCount = checks;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Region hit for an address, -1 when unmapped
    function automatic int refDecode(input opbAddr_t addr);
        longint unsigned a;
        longint unsigned lo;
        longint unsigned hi;
        int              hit;

        a   = 64'(addr);
        hit = -1;
        for (int i = 0; i < NumPeriph; i++) begin
            lo = 64'(PeriphBase[i]);
            hi = lo + 64'(PeriphSize[i]);
            if (hit < 0 && a >= lo && a < hi) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic periphStrobe_t expectedStrobe(input logic level, input int target);
        periphStrobe_t strobe;

        strobe = '0;
        if (level && target >= 0) begin
            strobe = periphStrobe_t'(1) << target;
        end
        return strobe;
    endfunction

    // Shared sources: both scratch words, all GPIO views
    function automatic logic [DataWidth-1:0] expectedWord(input int target);
        logic [DataWidth-1:0] word;

        word = '0;
        if (target >= 0) begin
            case (opbPeriph_t'(target))
                periphCounter:     word = counterData;
                periphScratch1:    word = scratchData;
                periphScratch2:    word = scratchData;
                periphClockGen:    word = clockGenData;
                periphAdc:         word = adcData;
                periphGantryMotor: word = gantryMotorData;
                periphLiftMotor:   word = liftMotorData;
                periphEeprom:      word = eepromData;
                periphGpioPower:   word = gpioData;
                periphGpioStand:   word = gpioData;
                periphGpioDebug:   word = gpioData;
                default:           word = '0;
            endcase
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic compareStrobe(input string name, input periphStrobe_t expected,
                                 input periphStrobe_t actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compareData(input string name, input logic [DataWidth-1:0] expected,
                               input logic [DataWidth-1:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // Inputs change on the rising edge, so mid-cycle values are settled
    always @(negedge OPB_CLK) begin
        int target;

        target = refDecode(opbAddr_t'(decAddr));
        compareStrobe("readStrobe", expectedStrobe(decRe, target), readStrobe);
        compareStrobe("writeStrobe", expectedStrobe(decWe, target), writeStrobe);
        compareData("decDo", expectedWord(prevTarget), decDo);

        if (OPB_RST) begin
            prevTarget = -1;
        end else begin
            prevTarget = decRe ? target : -1;
        end
    end

endmodule

/* addrDecodeTb.sv */
`timescale 1ns/1ps

// Testbench for the OPB address decoder
// Directed boundary, read-return, unmapped and dual-level sequences,
// followed by a random mix of accesses

module addrDecodeTb;

    import opbPkg::*;

    localparam int DataWidth = OpbDataWidth;
    localparam int AddrWidth = OpbAddrWidth;

    // Stimulus length in cycles
    localparam int ResetCycles    = 3;
    localparam int IdleCycles     = 4;
    localparam int WriteCycles    = NumPeriph * 3;
    localparam int ReadCycles     = NumPeriph * 2;
    localparam int NumUnmapped    = 10;
    localparam int BothCycles     = NumPeriph;
    localparam int RandomCycles   = 400;
    localparam int GapCycles      = 4;
    localparam int TailCycles     = 4;
    localparam int TotalCycles    = ResetCycles + IdleCycles + WriteCycles + ReadCycles
                                  + NumUnmapped + BothCycles + RandomCycles
                                  + GapCycles + TailCycles;
    localparam int TimeoutLimit   = TotalCycles + 50;

    // Outside every region, including one past several region ends
    localparam opbAddr_t UnmappedAddr [NumUnmapped] = '{
        32'h0000_0000, 32'h0000_0FFC, 32'h0000_1010, 32'h0000_1101, 32'h0000_1208,
        32'h0000_1320, 32'h0000_1601, 32'h0000_170C, 32'h0000_2000, 32'hFFFF_FFFF
    };

    logic                 OPB_CLK;
    logic                 OPB_RST;
    logic                 decRe;
    logic                 decWe;
    logic [AddrWidth-1:0] decAddr;
    logic [DataWidth-1:0] counterData;
    logic [DataWidth-1:0] scratchData;
    logic [DataWidth-1:0] clockGenData;
    logic [DataWidth-1:0] adcData;
    logic [DataWidth-1:0] gantryMotorData;
    logic [DataWidth-1:0] liftMotorData;
    logic [DataWidth-1:0] eepromData;
    logic [DataWidth-1:0] gpioData;
    periphStrobe_t        readStrobe;
    periphStrobe_t        writeStrobe;
    logic [DataWidth-1:0] decDo;

    int     errorCount;
    int     checkCount;
    int     assertFails;
    int     cycleCount = 0;
    integer seed = 67466;

    opbClockGen #(
        .PeriodNs    (20),
        .ResetCycles (ResetCycles)
    ) clockGen (
        .OPB_CLK (OPB_CLK),
        .OPB_RST (OPB_RST)
    );

    addrDecode #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) uut (
        .OPB_CLK         (OPB_CLK),
        .OPB_RST         (OPB_RST),
        .decRe           (decRe),
        .decWe           (decWe),
        .decAddr         (decAddr),
        .decDo           (decDo),
        .counterData     (counterData),
        .scratchData     (scratchData),
        .clockGenData    (clockGenData),
        .adcData         (adcData),
        .gantryMotorData (gantryMotorData),
        .liftMotorData   (liftMotorData),
        .eepromData      (eepromData),
        .gpioData        (gpioData),
        .readStrobe      (readStrobe),
        .writeStrobe     (writeStrobe)
    );

    addrDecodeChecker #(
        .DataWidth (DataWidth),
        .AddrWidth (AddrWidth)
    ) decodeCheck (
        .OPB_CLK         (OPB_CLK),
        .OPB_RST         (OPB_RST),
        .decRe           (decRe),
        .decWe           (decWe),
        .decAddr         (decAddr),
        .counterData     (counterData),
        .scratchData     (scratchData),
        .clockGenData    (clockGenData),
        .adcData         (adcData),
        .gantryMotorData (gantryMotorData),
        .liftMotorData   (liftMotorData),
        .eepromData      (eepromData),
        .gpioData        (gpioData),
        .readStrobe      (readStrobe),
        .writeStrobe     (writeStrobe),
        .decDo           (decDo),
        .errorCount      (errorCount),
        .checkCount      (checkCount)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic refreshData();
        counterData     <= $random(seed);
        scratchData     <= $random(seed);
        clockGenData    <= $random(seed);
        adcData         <= $random(seed);
        gantryMotorData <= $random(seed);
        liftMotorData   <= $random(seed);
        eepromData      <= $random(seed);
        gpioData        <= $random(seed);
    endtask

    task automatic driveAccess(input logic re, input logic we, input opbAddr_t addr);
        @(posedge OPB_CLK);
        decRe   <= re;
        decWe   <= we;
        decAddr <= addr;
        refreshData();
    endtask

    task automatic driveIdle();
        driveAccess(1'b0, 1'b0, '0);
    endtask

    // Inside a region, on its edges, or anywhere
    task automatic driveRandom();
        logic [31:0] rnd;
        logic [31:0] pick;
        opbPeriph_t  periph;
        opbAddr_t    addr;

        rnd    = $random(seed);
        pick   = $random(seed);
        periph = opbPeriph_t'(int'(pick[7:0]) % NumPeriph);
        case (rnd[3:2])
            2'd0, 2'd1: addr = PeriphBase[periph] + (32'(pick[31:8]) % PeriphSize[periph]);
            2'd2: begin
                case (rnd[5:4])
                    2'd0:    addr = PeriphBase[periph] - 32'd1;
                    2'd1:    addr = PeriphBase[periph] + PeriphSize[periph] - 32'd1;
                    2'd2:    addr = PeriphBase[periph] + PeriphSize[periph];
                    default: addr = PeriphBase[periph];
                endcase
            end
            default: addr = rnd[6] ? pick : (32'h0000_0F00 + {20'd0, pick[11:0]});
        endcase
        driveAccess(rnd[0], rnd[1], addr);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequences
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        decRe   <= 1'b0;
        decWe   <= 1'b0;
        decAddr <= '0;
        counterData     <= '0;
        scratchData     <= '0;
        clockGenData    <= '0;
        adcData         <= '0;
        gantryMotorData <= '0;
        liftMotorData   <= '0;
        eepromData      <= '0;
        gpioData        <= '0;

        @(negedge OPB_RST);
        repeat (IdleCycles) driveIdle();

        // First word, last word, one past the end
        for (int i = 0; i < NumPeriph; i++) begin
            driveAccess(1'b0, 1'b1, PeriphBase[i]);
            driveAccess(1'b0, 1'b1, PeriphBase[i] + PeriphSize[i] - 32'd1);
            driveAccess(1'b0, 1'b1, PeriphBase[i] + PeriphSize[i]);
        end
        driveIdle();

        // Back to back reads
        for (int i = 0; i < NumPeriph; i++) begin
            driveAccess(1'b1, 1'b0, PeriphBase[i]);
            driveAccess(1'b1, 1'b0, PeriphBase[i] + PeriphSize[i] - 32'd1);
        end
        driveIdle();

        for (int i = 0; i < NumUnmapped; i++) begin
            driveAccess(1'b1, i[0], UnmappedAddr[i]);
        end
        driveIdle();

        // Read and write levels together
        for (int i = 0; i < NumPeriph; i++) begin
            driveAccess(1'b1, 1'b1, PeriphBase[i] + PeriphSize[i] / 32'd2);
        end
        driveIdle();

        repeat (RandomCycles) driveRandom();
        repeat (TailCycles - 1) driveIdle();
        @(posedge OPB_CLK);

        assertFails = uut.readReturn.assertChecks.failCount;
        $display("Closing: %0d checks, %0d mismatches, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge OPB_CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout: stimulus did not finish within %0d cycles", TimeoutLimit);
            $display("Something failed");
            $finish;
        end
    end

endmodule

/* addrDecode_assertions.sv */
`timescale 1ns/1ps

// Read-return assertions, bound into opbReadReturn
// Watch the captured strobes and the returned word

module addrDecodeAssertions #(
    parameter int DataWidth = opbPkg::OpbDataWidth
) (
    input logic                  OPB_CLK,
    input logic                  OPB_RST,
    input opbPkg::periphStrobe_t readStrobeDly,
    input logic [DataWidth-1:0]  decDo
);

    int failCount = 0;

    // Regions are disjoint, so at most one read is in flight
    oneCaptured: assert property (
        @(posedge OPB_CLK) disable iff (OPB_RST) $onehot0(readStrobeDly)
    ) else begin
        failCount = failCount + 1;
        $error("More than one captured read strobe: %b", readStrobeDly);
    end

    // Idle bus reads as zero
    idleZero: assert property (
        @(posedge OPB_CLK) disable iff (OPB_RST) (readStrobeDly == '0) |-> (decDo == '0)
    ) else begin
        failCount = failCount + 1;
        $error("Return word %h with no captured read strobe", decDo);
    end

endmodule

bind opbReadReturn addrDecodeAssertions #(
    .DataWidth (DataWidth)
) assertChecks (
    .OPB_CLK       (OPB_CLK),
    .OPB_RST       (OPB_RST),
    .readStrobeDly (readStrobeDly),
    .decDo         (decDo)
);

/* opbAddrDecoder.sv */
`timescale 1ns/1ps

// OPB address decoder
// Matches the bus address against the region table and qualifies each
// hit with the read and write levels, all within the access cycle

module opbAddrDecoder #(
    parameter int AddrWidth = opbPkg::OpbAddrWidth
) (
    input  logic                  decRe,
    input  logic                  decWe,
    input  logic [AddrWidth-1:0]  decAddr,
    output opbPkg::periphStrobe_t readStrobe,
    output opbPkg::periphStrobe_t writeStrobe
);

    import opbPkg::*;

    // One bit wider than either address so base plus size cannot wrap
    localparam int CmpWidth = ((AddrWidth > OpbAddrWidth) ? AddrWidth : OpbAddrWidth) + 1;

    logic [CmpWidth-1:0] addrExt;
    periphStrobe_t       periphHit;

    assign addrExt = CmpWidth'(decAddr);

    ////////////////////////////////////////////////////////////////////////////
    // Region match
    ////////////////////////////////////////////////////////////////////////////

    // Half-open range [base, base + size)
    always_comb begin
        logic [CmpWidth-1:0] regionLo;
        logic [CmpWidth-1:0] regionHi;

        regionLo  = '0;
        regionHi  = '0;
        periphHit = '0;
        for (int i = 0; i < NumPeriph; i++) begin
            regionLo     = CmpWidth'(PeriphBase[i]);
            regionHi     = regionLo + CmpWidth'(PeriphSize[i]);
            periphHit[i] = (addrExt >= regionLo) && (addrExt < regionHi);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////////////////////

    // Both groups may fire together when both levels are high
    assign readStrobe  = periphHit & {NumPeriph{decRe}};
    assign writeStrobe = periphHit & {NumPeriph{decWe}};

endmodule

/* opbClockGen.sv */
`timescale 1ns/1ps

// Testbench clock and reset source for the OPB decoder
// Free-running clock, reset held high over the first rising edges

module opbClockGen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 3
) (
    output logic OPB_CLK,
    output logic OPB_RST
);

    initial OPB_CLK = 1'b0;

    always #(PeriodNs / 2) OPB_CLK = ~OPB_CLK;

    // Released on a rising edge, after the last reset cycle
    initial begin
        OPB_RST <= 1'b1;
        repeat (ResetCycles) @(posedge OPB_CLK);
        OPB_RST <= 1'b0;
    end

endmodule

/* opbPkg.sv */
// OPB address map for the motion-control board
// Bus widths, the peripheral selector and the region table used by the
// decoder and the read-return logic

package opbPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int OpbDataWidth = 32;
    localparam int OpbAddrWidth = 32;

    typedef logic [OpbAddrWidth-1:0] opbAddr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////////////////////

    // Listed in read priority order, lowest value wins
    typedef enum logic [3:0] {
        periphCounter,
        periphScratch1,
        periphScratch2,
        periphClockGen,
        periphAdc,
        periphGantryMotor,
        periphLiftMotor,
        periphEeprom,
        periphGpioPower,
        periphGpioStand,
        periphGpioDebug
    } opbPeriph_t;

    localparam int NumPeriph = 11;

    // Bit index is the enum value
    typedef logic [NumPeriph-1:0] periphStrobe_t;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // Region base, one entry per enum member in enum order
    localparam opbAddr_t PeriphBase [NumPeriph] = '{
        32'h0000_1000,  // event counter
        32'h0000_1100,  // scratch word 1
        32'h0000_1104,  // scratch word 2
        32'h0000_1200,  // clock generator
        32'h0000_1300,  // ADC
        32'h0000_1400,  // gantry motor
        32'h0000_1500,  // lift motor
        32'h0000_1600,  // EEPROM port
        32'h0000_1700,  // GPIO power view
        32'h0000_1704,  // GPIO stand view
        32'h0000_1708   // GPIO debug view
    };

    // Region size in addresses, 1 means exact match
    localparam int unsigned PeriphSize [NumPeriph] = '{
        16,             // event counter
        1,
        1,
        8,              // clock generator
        32,             // ADC
        64,             // gantry motor
        64,             // lift motor
        1,
        1,
        1,
        1
    };

endpackage

/* opbReadReturn.sv */
`timescale 1ns/1ps

// OPB read return path
// Delays the read strobes by one clock and places the word of the
// selected peripheral on the bus in the following cycle

module opbReadReturn #(
    parameter int DataWidth = opbPkg::OpbDataWidth
) (
    input  logic                  OPB_CLK,
    input  logic                  OPB_RST,
    input  opbPkg::periphStrobe_t readStrobe,
    input  logic [DataWidth-1:0]  counterData,
    input  logic [DataWidth-1:0]  scratchData,
    input  logic [DataWidth-1:0]  clockGenData,
    input  logic [DataWidth-1:0]  adcData,
    input  logic [DataWidth-1:0]  gantryMotorData,
    input  logic [DataWidth-1:0]  liftMotorData,
    input  logic [DataWidth-1:0]  eepromData,
    input  logic [DataWidth-1:0]  gpioData,
    output logic [DataWidth-1:0]  decDo
);

    import opbPkg::*;

    periphStrobe_t        readStrobeDly;
    logic [DataWidth-1:0] periphWord [NumPeriph];

    ////////////////////////////////////////////////////////////////////////////
    // Delayed read strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            readStrobeDly <= '0;
        end else begin
            readStrobeDly <= readStrobe;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Return data
    ////////////////////////////////////////////////////////////////////////////

    // Data source behind each peripheral
    always_comb begin
        for (int i = 0; i < NumPeriph; i++) begin
            case (opbPeriph_t'(i))
                periphCounter:     periphWord[i] = counterData;
                periphScratch1:    periphWord[i] = scratchData;
                periphScratch2:    periphWord[i] = scratchData;
                periphClockGen:    periphWord[i] = clockGenData;
                periphAdc:         periphWord[i] = adcData;
                periphGantryMotor: periphWord[i] = gantryMotorData;
                periphLiftMotor:   periphWord[i] = liftMotorData;
                periphEeprom:      periphWord[i] = eepromData;
                // All GPIO views read the same port
                periphGpioPower:   periphWord[i] = gpioData;
                periphGpioStand:   periphWord[i] = gpioData;
                periphGpioDebug:   periphWord[i] = gpioData;
                default:           periphWord[i] = '0;
            endcase
        end
    end

    // First captured strobe wins, idle bus reads as zero
    always_comb begin
        logic found;

        found = 1'b0;
        decDo = '0;
        for (int i = 0; i < NumPeriph; i++) begin
            if (readStrobeDly[i] && !found) begin
                decDo = periphWord[i];
                found = 1'b1;
            end
        end
    end

endmodule

/* runSim.sh */
#!/bin/sh
# Build and run the OPB address decoder testbench with Verilator

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module addrDecodeTb \
    -f addrDecode.f -o simAddrDecode > build.log 2>&1 \
    && ./obj_dir/simAddrDecode +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "Everything OK" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
